// ==== jesd_lane_pkg.sv ====
// ****************************
// jesd lane package
// lane-side widths, lane count and byte offset type
// ****************************

package jesd_lane_pkg;

  // ****************************
  // lane geometry
  // ****************************

  // four lanes, line rate / 40 per rx_clk
  localparam int num_lanes = 4;

  // one lane word per rx_clk
  localparam int lane_width = 32;

  // start-of-frame flags, one per byte position
  localparam int lane_bytes = lane_width / 8;

  // all lanes side by side
  localparam int frame_width = num_lanes * lane_width;

  // ****************************
  // frame alignment
  // ****************************

  // byte where the frame starts inside a lane word
  typedef logic [1:0] byte_offset_t;

endpackage

// ==== adc_sync_pkg.sv ====
// ****************************
// adc sample package
// sample widths, buffer geometry and sync state
// ****************************

package adc_sync_pkg;

  // ****************************
  // samples
  // ****************************

  localparam int num_channels = 8;
  localparam int sample_width = 16;

  // channel d carries the start code
  localparam int sync_channel = 3;

  // ****************************
  // frame buffer
  // ****************************

  localparam int buf_addr_width = 4;
  localparam int buf_depth = 1 << buf_addr_width;

  // read side runs half a buffer ahead of the write side
  localparam logic [buf_addr_width-1:0] read_offset = buf_addr_width'(buf_depth / 2);

  // sync request handshake with software
  typedef enum logic {
    SYNC_IDLE  = 1'b0,
    SYNC_ARMED = 1'b1
  } sync_state_t;

endpackage

// ==== jesd_lane_align.sv ====
// ****************************
// jesd lane aligner
// shifts one lane word so the frame starts at byte 0
// ****************************

`timescale 1ns/1ps

module jesd_lane_align (
  input  logic                                   rx_clk,
  input  logic                                   adc_rst,
  input  logic [jesd_lane_pkg::lane_bytes-1:0]   rx_sof,
  input  logic [jesd_lane_pkg::lane_width-1:0]   lane_in,
  output logic                                   lane_sof,
  output logic [jesd_lane_pkg::lane_width-1:0]   lane_data
);

  import jesd_lane_pkg::*;

  logic [lane_width-1:0]   lane_prev;
  logic [2*lane_width-1:0] lane_window;
  byte_offset_t            sof_offset;
  byte_offset_t            off_q;
  logic                    sof_d;

  // lowest flagged byte wins
  always_comb begin
    sof_offset = '0;
    for (int i = lane_bytes - 1; i >= 0; i--) begin
      if (rx_sof[i]) begin
        sof_offset = byte_offset_t'(i);
      end
    end
  end

  // previous word in the low half, so byte k of it is window byte k
  assign lane_window = {lane_in, lane_prev};

  always_ff @(posedge rx_clk) begin
    lane_prev <= lane_in;
    // a frame flagged in word t is complete once word t+1 is here
    lane_data <= lane_window[off_q*8 +: lane_width];
  end

  // ****************************
  // offset and frame marker
  // ****************************

  always_ff @(posedge rx_clk) begin
    if (adc_rst) begin
      off_q    <= '0;
      sof_d    <= 1'b0;
      lane_sof <= 1'b0;
    end else begin
      if (|rx_sof) begin
        off_q <= sof_offset;
      end
      // marker lines up with the word that holds the whole frame
      sof_d    <= |rx_sof;
      lane_sof <= sof_d;
    end
  end

  // only one frame can start per lane word
  a_sof_onehot : assert property (
    @(posedge rx_clk) disable iff (adc_rst)
    (|rx_sof) |-> $onehot(rx_sof)
  );

endmodule

// ==== sample_assembler.sv ====
// ****************************
// sample assembler
// joins the lanes into a frame and swaps to host order
// ****************************

`timescale 1ns/1ps

module sample_assembler (
  input  logic                                   rx_clk,
  input  logic                                   adc_rst,
  input  logic [jesd_lane_pkg::num_lanes-1:0]    lane_sof,
  input  logic [jesd_lane_pkg::frame_width-1:0]  lane_data,
  output logic                                   frame_valid,
  output logic [jesd_lane_pkg::frame_width-1:0]  frame_data
);

  import adc_sync_pkg::*;

  localparam int half_sample = sample_width / 2;

  logic all_sof;

  // every lane sees the same frame boundary
  assign all_sof = &lane_sof;

  // ****************************
  // frame valid
  // ****************************

  // stream never stops once the first frame is seen
  always_ff @(posedge rx_clk) begin
    if (adc_rst) begin
      frame_valid <= 1'b0;
    end else if (all_sof) begin
      frame_valid <= 1'b1;
    end
  end

  // ****************************
  // byte swap
  // ****************************

  // network order puts the msb first on the wire, i.e. in the low byte
  always_ff @(posedge rx_clk) begin
    for (int c = 0; c < num_channels; c++) begin
      frame_data[c*sample_width +: sample_width] <= {
        lane_data[c*sample_width +: half_sample],
        lane_data[c*sample_width + half_sample +: half_sample]
      };
    end
  end

  // lanes share rx_sof, so a split marker means a broken aligner
  a_lane_sof_agree : assert property (
    @(posedge rx_clk) disable iff (adc_rst)
    all_sof || !(|lane_sof)
  );

endmodule

// ==== sync_ctrl.sv ====
// ****************************
// sync control
// start-code detection and buffer pointer control
// ****************************

`timescale 1ns/1ps

module sync_ctrl (
  input  logic                                     rx_clk,
  input  logic                                     adc_rst,
  input  logic                                     frame_valid,
  input  logic [adc_sync_pkg::sample_width-1:0]    sync_sample,
  input  logic [adc_sync_pkg::sample_width-1:0]    start_code,
  input  logic                                     adc_sync,
  output logic                                     wr_en,
  output logic [adc_sync_pkg::buf_addr_width-1:0]  wr_addr,
  output logic [adc_sync_pkg::buf_addr_width-1:0]  rd_addr,
  output logic                                     adc_sync_status,
  output logic                                     adc_status
);

  import adc_sync_pkg::*;

  sync_state_t               state_q;
  logic                      restart;
  logic [buf_addr_width-1:0] wr_ptr;
  logic [buf_addr_width-1:0] rd_ptr;
  logic [buf_addr_width-1:0] ptr_gap;

  // start code only counts while armed
  assign restart = frame_valid && (state_q == SYNC_ARMED) && (sync_sample == start_code);

  // the start-code frame itself lands at address 0
  assign wr_en   = frame_valid;
  assign wr_addr = restart ? '0 : wr_ptr;
  assign rd_addr = restart ? read_offset : rd_ptr;

  assign adc_sync_status = (state_q == SYNC_ARMED);

  // ****************************
  // sync fsm
  // ****************************

  always_ff @(posedge rx_clk) begin
    if (adc_rst) begin
      state_q <= SYNC_IDLE;
    end else begin
      case (state_q)
        SYNC_IDLE: begin
          if (adc_sync) begin
            state_q <= SYNC_ARMED;
          end
        end
        SYNC_ARMED: begin
          if (restart) begin
            state_q <= SYNC_IDLE;
          end
        end
        default: begin
          state_q <= SYNC_IDLE;
        end
      endcase
    end
  end

  // one step per valid frame, from the restarted value if any
  always_ff @(posedge rx_clk) begin
    if (adc_rst) begin
      wr_ptr <= '0;
      rd_ptr <= read_offset;
    end else if (frame_valid) begin
      wr_ptr <= wr_addr + 1'b1;
      rd_ptr <= rd_addr + 1'b1;
    end
  end

  always_ff @(posedge rx_clk) begin
    if (adc_rst) begin
      adc_status <= 1'b0;
    end else begin
      adc_status <= 1'b1;
    end
  end

  // reader never catches up with the writer
  assign ptr_gap = rd_addr - wr_addr;

  a_ptr_gap : assert property (
    @(posedge rx_clk) disable iff (adc_rst)
    ptr_gap == read_offset
  );

endmodule

// ==== sync_buffer.sv ====
// ****************************
// sync buffer
// frame memory and registered channel outputs
// ****************************

`timescale 1ns/1ps

module sync_buffer (
  input  logic                                     rx_clk,
  input  logic                                     adc_rst,
  input  logic                                     wr_en,
  input  logic [adc_sync_pkg::buf_addr_width-1:0]  wr_addr,
  input  logic [jesd_lane_pkg::frame_width-1:0]    wr_data,
  input  logic [adc_sync_pkg::buf_addr_width-1:0]  rd_addr,
  input  logic                                     frame_valid,
  output logic                                     adc_valid,
  output logic [adc_sync_pkg::sample_width-1:0]    adc_data_a,
  output logic [adc_sync_pkg::sample_width-1:0]    adc_data_b,
  output logic [adc_sync_pkg::sample_width-1:0]    adc_data_c,
  output logic [adc_sync_pkg::sample_width-1:0]    adc_data_d,
  output logic [adc_sync_pkg::sample_width-1:0]    adc_data_e,
  output logic [adc_sync_pkg::sample_width-1:0]    adc_data_f,
  output logic [adc_sync_pkg::sample_width-1:0]    adc_data_g,
  output logic [adc_sync_pkg::sample_width-1:0]    adc_data_h
);

  import jesd_lane_pkg::*;
  import adc_sync_pkg::*;

  logic [frame_width-1:0]  mem [buf_depth];
  logic [frame_width-1:0]  rd_word;
  logic [sample_width-1:0] chan_q [num_channels];
  logic                    valid_d;

  // ****************************
  // frame memory
  // ****************************

  always_ff @(posedge rx_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    rd_word <= mem[rd_addr];
  end

  // second stage splits the word into channels
  always_ff @(posedge rx_clk) begin
    for (int c = 0; c < num_channels; c++) begin
      chan_q[c] <= rd_word[c*sample_width +: sample_width];
    end
  end

  // valid tracks the two read stages
  always_ff @(posedge rx_clk) begin
    if (adc_rst) begin
      valid_d   <= 1'b0;
      adc_valid <= 1'b0;
    end else begin
      valid_d   <= frame_valid;
      adc_valid <= valid_d;
    end
  end

  assign adc_data_a = chan_q[0];
  assign adc_data_b = chan_q[1];
  assign adc_data_c = chan_q[2];
  assign adc_data_d = chan_q[3];
  assign adc_data_e = chan_q[4];
  assign adc_data_f = chan_q[5];
  assign adc_data_g = chan_q[6];
  assign adc_data_h = chan_q[7];

endmodule

// ==== adc_rx_if.sv ====
// ****************************
// adc receive interface
// four jesd lanes in, eight synced channels out
// ****************************

`timescale 1ns/1ps

module adc_rx_if (
  input  logic                                   rx_clk,
  input  logic                                   adc_rst,
  input  logic [jesd_lane_pkg::lane_bytes-1:0]   rx_sof,
  input  logic [jesd_lane_pkg::frame_width-1:0]  rx_data,
  input  logic [adc_sync_pkg::sample_width-1:0]  start_code,
  input  logic                                   adc_sync,
  output logic                                   adc_valid,
  output logic [adc_sync_pkg::sample_width-1:0]  adc_data_a,
  output logic [adc_sync_pkg::sample_width-1:0]  adc_data_b,
  output logic [adc_sync_pkg::sample_width-1:0]  adc_data_c,
  output logic [adc_sync_pkg::sample_width-1:0]  adc_data_d,
  output logic [adc_sync_pkg::sample_width-1:0]  adc_data_e,
  output logic [adc_sync_pkg::sample_width-1:0]  adc_data_f,
  output logic [adc_sync_pkg::sample_width-1:0]  adc_data_g,
  output logic [adc_sync_pkg::sample_width-1:0]  adc_data_h,
  output logic                                   adc_sync_status,
  output logic                                   adc_status
);

  import jesd_lane_pkg::*;
  import adc_sync_pkg::*;

  logic [num_lanes-1:0]      lane_sof;
  logic [frame_width-1:0]    lane_data;
  logic                      frame_valid;
  logic [frame_width-1:0]    frame_data;
  logic [sample_width-1:0]   sync_sample;
  logic                      wr_en;
  logic [buf_addr_width-1:0] wr_addr;
  logic [buf_addr_width-1:0] rd_addr;

  // ****************************
  // lane alignment
  // ****************************

  for (genvar n = 0; n < num_lanes; n++) begin : g_lane
    jesd_lane_align i_lane_align (
      .rx_clk    (rx_clk),
      .adc_rst   (adc_rst),
      .rx_sof    (rx_sof),
      .lane_in   (rx_data[n*lane_width +: lane_width]),
      .lane_sof  (lane_sof[n]),
      .lane_data (lane_data[n*lane_width +: lane_width])
    );
  end

  sample_assembler i_sample_assembler (
    .rx_clk      (rx_clk),
    .adc_rst     (adc_rst),
    .lane_sof    (lane_sof),
    .lane_data   (lane_data),
    .frame_valid (frame_valid),
    .frame_data  (frame_data)
  );

  // ****************************
  // sync and buffer
  // ****************************

  // channel d in host order
  assign sync_sample = frame_data[sync_channel*sample_width +: sample_width];

  sync_ctrl i_sync_ctrl (
    .rx_clk          (rx_clk),
    .adc_rst         (adc_rst),
    .frame_valid     (frame_valid),
    .sync_sample     (sync_sample),
    .start_code      (start_code),
    .adc_sync        (adc_sync),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .rd_addr         (rd_addr),
    .adc_sync_status (adc_sync_status),
    .adc_status      (adc_status)
  );

  sync_buffer i_sync_buffer (
    .rx_clk      (rx_clk),
    .adc_rst     (adc_rst),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (frame_data),
    .rd_addr     (rd_addr),
    .frame_valid (frame_valid),
    .adc_valid   (adc_valid),
    .adc_data_a  (adc_data_a),
    .adc_data_b  (adc_data_b),
    .adc_data_c  (adc_data_c),
    .adc_data_d  (adc_data_d),
    .adc_data_e  (adc_data_e),
    .adc_data_f  (adc_data_f),
    .adc_data_g  (adc_data_g),
    .adc_data_h  (adc_data_h)
  );

endmodule

// ==== tb_adc_rx_if.sv ====
// ****************************
// adc receive interface testbench
// directed tests against a frame buffer model
// ****************************

`timescale 1ns/1ps

module tb_adc_rx_if;

  import jesd_lane_pkg::*;
  import adc_sync_pkg::*;

  localparam int clk_period = 40;
  localparam int frame_bytes = frame_width / 8;
  localparam logic [sample_width-1:0] code = 16'hA5C3;
  // cycles of each test in run order, plus half again for the watchdog
  localparam int run_cycles = 6 + 24 + 72 + 34 + 41 + 39;
  localparam int watchdog_cycles = run_cycles * 3 / 2;

  logic                    rx_clk;
  logic                    adc_rst;
  logic [lane_bytes-1:0]   rx_sof;
  logic [frame_width-1:0]  rx_data;
  logic [sample_width-1:0] start_code;
  logic                    adc_sync;
  logic                    adc_valid;
  logic [sample_width-1:0] adc_data_a;
  logic [sample_width-1:0] adc_data_b;
  logic [sample_width-1:0] adc_data_c;
  logic [sample_width-1:0] adc_data_d;
  logic [sample_width-1:0] adc_data_e;
  logic [sample_width-1:0] adc_data_f;
  logic [sample_width-1:0] adc_data_g;
  logic [sample_width-1:0] adc_data_h;
  logic                    adc_sync_status;
  logic                    adc_status;

  // stimulus and model state
  logic [31:0]               rng = 32'd11;
  logic [7:0]                prev_b [frame_bytes];
  int                        prev_off;
  logic [frame_width-1:0]    mem_model [buf_depth];
  bit                        mem_known [buf_depth];
  logic [buf_addr_width-1:0] model_wr;
  logic [buf_addr_width-1:0] model_rd;
  bit                        model_armed;
  logic [frame_width-1:0]    exp_q [$];
  bit                        known_q [$];
  logic [frame_width-1:0]    out_frame;
  logic [frame_width-1:0]    exp_frame;
  string                     cur_test;
  int                        checks;
  int                        total_errors;
  int                        test_errors;
  int                        frames_checked;
  int                        frames_at_start;

  adc_rx_if i_adc_rx_if (.*);

  initial begin
    rx_clk = 1'b0;
    forever #(clk_period / 2) rx_clk = ~rx_clk;
  end

  // ****************************
  // checks
  // ****************************

  task automatic count_error();
    total_errors++;
    test_errors++;
  endtask

  task automatic check_sample(input string what, input logic [sample_width-1:0] exp,
                              input logic [sample_width-1:0] act);
    checks++;
    if (act !== exp) begin
      $display("FAILED %s %s: expected %04h actual %04h", cur_test, what, exp, act);
      count_error();
    end
  endtask

  task automatic check_frame(input string what, input logic [frame_width-1:0] exp,
                             input logic [frame_width-1:0] act);
    for (int c = 0; c < num_channels; c++) begin
      check_sample($sformatf("%s ch %c", what, 8'(97 + c)),
                   exp[c*sample_width +: sample_width], act[c*sample_width +: sample_width]);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      $display("FAILED %s %s: expected %0b actual %0b", cur_test, what, exp, act);
      count_error();
    end
  endtask

  // every valid output takes the next predicted frame
  always @(negedge rx_clk) begin
    if (!adc_rst && adc_valid === 1'b1) begin
      out_frame = {adc_data_h, adc_data_g, adc_data_f, adc_data_e,
                   adc_data_d, adc_data_c, adc_data_b, adc_data_a};
      if (exp_q.size() == 0) begin
        $display("error in %s: adc_valid high with no frame outstanding", cur_test);
        count_error();
      end else begin
        exp_frame = exp_q.pop_front();
        if (known_q.pop_front()) begin
          check_frame("output", exp_frame, out_frame);
          frames_checked++;
        end
      end
    end
  end

  // ****************************
  // stimulus and model
  // ****************************

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // channel d never hits the start code by chance
  function automatic logic [frame_width-1:0] random_frame();
    logic [frame_width-1:0] f;
    for (int c = 0; c < num_channels; c++) begin
      rng = xorshift32(rng);
      f[c*sample_width +: sample_width] = rng[15:0];
    end
    if (f[sync_channel*sample_width +: sample_width] == code) begin
      f[sync_channel*sample_width +: sample_width] ^= 16'h0001;
    end
    return f;
  endfunction

  function automatic logic [frame_width-1:0] code_frame();
    logic [frame_width-1:0] f;
    f = random_frame();
    f[sync_channel*sample_width +: sample_width] = code;
    return f;
  endfunction

  // buffer rule: read old entry, write new one, restart on an armed start code
  task automatic model_frame(input logic [frame_width-1:0] smp);
    if (model_armed && smp[sync_channel*sample_width +: sample_width] == code) begin
      model_armed = 1'b0;
      model_wr = '0;
      model_rd = read_offset;
    end
    exp_q.push_back(mem_model[model_rd]);
    known_q.push_back(mem_known[model_rd]);
    mem_model[model_wr] = smp;
    mem_known[model_wr] = 1'b1;
    model_wr = model_wr + 4'd1;
    model_rd = model_rd + 4'd1;
  endtask

  // two samples per lane, msb first on the wire, frame starts at byte off
  task automatic send_frame(input logic [frame_width-1:0] smp, input byte_offset_t off);
    logic [7:0]             cur_b [frame_bytes];
    logic [frame_width-1:0] word;
    int                     ch;
    for (int n = 0; n < num_lanes; n++) begin
      for (int j = 0; j < lane_bytes; j++) begin
        ch = n * 2 + j / 2;
        cur_b[n*lane_bytes+j] = (j % 2 == 0) ? smp[ch*sample_width + 8 +: 8]
                                             : smp[ch*sample_width +: 8];
      end
      for (int p = 0; p < lane_bytes; p++) begin
        if (p < prev_off) begin
          word[(n*lane_bytes+p)*8 +: 8] = prev_b[n*lane_bytes + lane_bytes - prev_off + p];
        end else if (p >= int'(off)) begin
          word[(n*lane_bytes+p)*8 +: 8] = cur_b[n*lane_bytes + p - int'(off)];
        end else begin
          word[(n*lane_bytes+p)*8 +: 8] = 8'h00;
        end
      end
    end
    @(posedge rx_clk);
    #2;
    rx_data = word;
    rx_sof = 4'b0001 << off;
    prev_b = cur_b;
    prev_off = int'(off);
    model_frame(smp);
  endtask

  task automatic stream(input int n, input byte_offset_t off);
    repeat (n) send_frame(random_frame(), off);
  endtask

  task automatic arm_sync(input byte_offset_t off);
    adc_sync = 1'b1;
    model_armed = 1'b1;
    send_frame(random_frame(), off);
    adc_sync = 1'b0;
    check_flag("adc_sync_status after adc_sync", 1'b1, adc_sync_status);
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    test_errors = 0;
    frames_at_start = frames_checked;
  endtask

  task automatic finish_test(input int min_frames);
    if (frames_checked - frames_at_start < min_frames) begin
      $display("error in %s: only %0d output frames were checked", cur_test,
               frames_checked - frames_at_start);
      count_error();
    end
    if (test_errors == 0) begin
      $display("test %s: ok", cur_test);
    end else begin
      $display("test %s: %0d errors", cur_test, test_errors);
    end
  endtask

  // ****************************
  // tests
  // ****************************

  task automatic reset_state();
    begin_test("reset_state");
    repeat (5) begin
      @(posedge rx_clk);
      #2;
      check_flag("adc_valid in reset", 1'b0, adc_valid);
      check_flag("adc_sync_status in reset", 1'b0, adc_sync_status);
      check_flag("adc_status in reset", 1'b0, adc_status);
    end
    adc_rst = 1'b0;
    @(posedge rx_clk);
    #2;
    check_flag("adc_valid after reset", 1'b0, adc_valid);
    check_flag("adc_sync_status after reset", 1'b0, adc_sync_status);
    check_flag("adc_status after reset", 1'b1, adc_status);
    finish_test(0);
  endtask

  task automatic byte_order();
    begin_test("byte_order");
    stream(24, 2'd0);
    finish_test(8);
  endtask

  task automatic lane_alignment();
    begin_test("lane_alignment");
    for (int off = 1; off < lane_bytes; off++) begin
      stream(24, byte_offset_t'(off));
    end
    finish_test(40);
  endtask

  task automatic sync_arming();
    int waited;
    begin_test("sync_arming");
    stream(2, 2'd3);
    check_flag("adc_sync_status before arming", 1'b0, adc_sync_status);
    arm_sync(2'd3);
    repeat (6) begin
      stream(1, 2'd3);
      check_flag("adc_sync_status while armed", 1'b1, adc_sync_status);
    end
    send_frame(code_frame(), 2'd3);
    check_flag("adc_sync_status on start code", 1'b1, adc_sync_status);
    waited = 0;
    while (adc_sync_status === 1'b1 && waited < 10) begin
      stream(1, 2'd3);
      waited++;
    end
    if (adc_sync_status !== 1'b0) begin
      $display("error in %s: adc_sync_status did not clear after the start code", cur_test);
      count_error();
    end
    stream(14, 2'd3);
    finish_test(10);
  endtask

  // start frame must come out 8 frames after its restart slot
  task automatic restart_latency();
    begin_test("restart_latency");
    arm_sync(2'd3);
    stream(5, 2'd3);
    send_frame(code_frame(), 2'd3);
    stream(20, 2'd3);
    check_flag("adc_sync_status after restart", 1'b0, adc_sync_status);
    stream(14, 2'd3);
    finish_test(20);
  endtask

  task automatic unarmed_start_code();
    begin_test("unarmed_start_code");
    stream(4, 2'd3);
    send_frame(code_frame(), 2'd3);
    stream(20, 2'd3);
    check_flag("adc_sync_status unarmed", 1'b0, adc_sync_status);
    stream(14, 2'd3);
    finish_test(20);
  endtask

  initial begin
    adc_rst = 1'b1;
    rx_sof = '0;
    rx_data = '0;
    start_code = code;
    adc_sync = 1'b0;
    prev_off = 0;
    model_wr = '0;
    model_rd = read_offset;
    model_armed = 1'b0;
    reset_state();
    byte_order();
    lane_alignment();
    sync_arming();
    restart_latency();
    unarmed_start_code();
    $display("summary: %0d checks, %0d frames compared, %0d errors",
             checks, frames_checked, total_errors);
    if (total_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog: tests did not finish within %0d cycles", watchdog_cycles);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== verilog.f ====
jesd_lane_pkg.sv
adc_sync_pkg.sv
jesd_lane_align.sv
sample_assembler.sv
sync_ctrl.sv
sync_buffer.sv
adc_rx_if.sv
tb_adc_rx_if.sv

// ==== Makefile ====
# Verilator build and run for the adc receive interface

VERILATOR ?= verilator
TOP       ?= tb_adc_rx_if
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "TESTS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
